// ==== hw/sep_config.svh ====
// wave separator configuration
`ifndef SEP_CONFIG_SVH
`define SEP_CONFIG_SVH

// bins per frame, power of two
`define SEP_FRAME_LEN 64

// bin index width
`define SEP_BIN_W ($clog2(`SEP_FRAME_LEN))

// rebuilt triangle harmonics, odd k from 1 to 17
// each one falls roughly as 1/k^2 of the fundamental
`define SEP_TRI_AMP_1  26000
`define SEP_TRI_AMP_3  3000
`define SEP_TRI_AMP_5  1000
`define SEP_TRI_AMP_7  550
`define SEP_TRI_AMP_9  330
`define SEP_TRI_AMP_11 220
`define SEP_TRI_AMP_13 176
`define SEP_TRI_AMP_15 124
`define SEP_TRI_AMP_17 97

// rebuilt sine fundamental
`define SEP_SIN_AMP 32400

// triangle threshold: third harmonic above fundamental >> shift
// 4 gives 1/16 of the fundamental
`define SEP_TRI_SHIFT 4

`endif

// ==== hw/sep_pkg.sv ====
// wave separator types
`include "sep_config.svh"

package sep_pkg;

    // bin index inside one frame
    typedef logic [`SEP_BIN_W-1:0] bin_t;

    // input spectrum magnitude, unsigned
    typedef logic [31:0] mag_t;

    // rebuilt amplitude, unsigned
    typedef logic [15:0] amp_t;

    // bit 0 low peak is triangle, bit 1 high peak is triangle
    typedef logic [1:0] wave_flags_t;

    // sequencing of one frame
    typedef enum logic [1:0] {
        ST_LOAD,     // accepting input bins
        ST_CLASSIFY, // third harmonic lookup
        ST_SYNTH     // streaming rebuilt spectrum
    } ctrl_state_t;

endpackage

// ==== hw/spectrum_buffer.sv ====
// magnitude frame store
`timescale 1ns/1ps
`include "sep_config.svh"

module spectrum_buffer (
    input  logic          AD0_CLK,
    input  logic          we,
    input  sep_pkg::bin_t waddr,
    input  sep_pkg::mag_t wdata,
    input  sep_pkg::bin_t raddr,
    output sep_pkg::mag_t rdata
);
    import sep_pkg::*;

    // one entry per bin
    mag_t mem [0:`SEP_FRAME_LEN-1];

    always_ff @(posedge AD0_CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge AD0_CLK) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== hw/peak_finder.sv ====
// two largest fundamentals of a frame
`timescale 1ns/1ps
`include "sep_config.svh"

module peak_finder (
    input  logic          AD0_CLK,
    input  logic          rst,
    input  logic          load_active,
    input  logic          beat,
    input  sep_pkg::mag_t mag,
    output sep_pkg::bin_t wr_bin,
    output sep_pkg::bin_t fund_lo,
    output sep_pkg::bin_t fund_hi,
    output sep_pkg::mag_t fund_lo_mag,
    output sep_pkg::mag_t fund_hi_mag
);
    import sep_pkg::*;

    localparam bin_t HALF = bin_t'(`SEP_FRAME_LEN / 2);
    localparam bin_t LAST = bin_t'(`SEP_FRAME_LEN - 1);

    // running winners, best and runner-up
    mag_t best_mag, sec_mag;
    bin_t best_bin, sec_bin;
    logic candidate;

    // only the lower half-spectrum, bin 0 is dc
    assign candidate = beat && (wr_bin != '0) && (wr_bin < HALF);

    always_ff @(posedge AD0_CLK) begin
        if (rst || !load_active) begin
            wr_bin <= '0; // resync between frames
        end else if (beat) begin
            wr_bin <= wr_bin + 1'b1;
        end
    end

    always_ff @(posedge AD0_CLK) begin
        if (rst || (beat && wr_bin == '0)) begin
            best_mag <= '0; // fresh frame
            sec_mag  <= '0;
            best_bin <= '0;
            sec_bin  <= '0;
        end else if (candidate) begin
            if (mag > best_mag) begin
                sec_mag  <= best_mag;
                sec_bin  <= best_bin;
                best_mag <= mag;
                best_bin <= wr_bin;
            end else if (mag > sec_mag) begin
                sec_mag <= mag;
                sec_bin <= wr_bin;
            end
        end
    end

    // upper half never changes the winners, so the final beat can publish them
    always_ff @(posedge AD0_CLK) begin
        if (rst) begin
            fund_lo     <= '0;
            fund_hi     <= '0;
            fund_lo_mag <= '0;
            fund_hi_mag <= '0;
        end else if (beat && wr_bin == LAST) begin
            if (best_bin < sec_bin) begin
                fund_lo     <= best_bin;
                fund_lo_mag <= best_mag;
                fund_hi     <= sec_bin;
                fund_hi_mag <= sec_mag;
            end else begin
                fund_lo     <= sec_bin;
                fund_lo_mag <= sec_mag;
                fund_hi     <= best_bin;
                fund_hi_mag <= best_mag;
            end
        end
    end

endmodule

// ==== hw/wave_classifier.sv ====
// sine or triangle decision per fundamental
`timescale 1ns/1ps
`include "sep_config.svh"

module wave_classifier (
    input  logic                 AD0_CLK,
    input  logic                 rst,
    input  logic                 start,
    input  sep_pkg::bin_t        fund_lo,
    input  sep_pkg::bin_t        fund_hi,
    input  sep_pkg::mag_t        fund_lo_mag,
    input  sep_pkg::mag_t        fund_hi_mag,
    output sep_pkg::bin_t        raddr,
    input  sep_pkg::mag_t        rdata,
    output sep_pkg::wave_flags_t tri_flags,
    output logic                 done
);
    import sep_pkg::*;

    localparam int HALF = `SEP_FRAME_LEN / 2;

    logic [2:0] step;               // 0 idle, 1..5 busy
    logic [`SEP_BIN_W+1:0] t3_lo, t3_hi; // 3f, wide enough not to wrap
    mag_t thr_lo, thr_hi;
    logic hit_lo, hit_hi;
    wave_flags_t flags_q;

    always_ff @(posedge AD0_CLK) begin
        if (rst) begin
            step <= '0;
        end else if (start) begin
            step <= 3'd1;
        end else if (step == 3'd5) begin
            step <= '0;
        end else if (step != '0) begin
            step <= step + 3'd1;
        end
    end

    // datapath: address, compares, flag assembly
    always_ff @(posedge AD0_CLK) begin
        if (start) begin
            t3_lo  <= {2'b00, fund_lo} + {1'b0, fund_lo, 1'b0};
            t3_hi  <= {2'b00, fund_hi} + {1'b0, fund_hi, 1'b0};
            thr_lo <= fund_lo_mag >> `SEP_TRI_SHIFT;
            thr_hi <= fund_hi_mag >> `SEP_TRI_SHIFT;
            raddr  <= fund_lo + {fund_lo[`SEP_BIN_W-2:0], 1'b0};
        end
        case (step)
            3'd1: raddr  <= t3_hi[`SEP_BIN_W-1:0];
            3'd2: hit_lo <= rdata > thr_lo;  // bin 3*lo arrived
            3'd3: hit_hi <= rdata > thr_hi;
            3'd4: flags_q <= {hit_hi && (int'(t3_hi) < HALF), hit_lo && (int'(t3_lo) < HALF)};
            default: ;
        endcase
    end

    always_ff @(posedge AD0_CLK) begin
        if (rst) begin
            tri_flags <= '0;
            done      <= 1'b0;
        end else begin
            done <= (step == 3'd5); // six cycles after start
            if (step == 3'd5) begin
                tri_flags <= flags_q;
            end
        end
    end

endmodule

// ==== hw/harmonic_synth.sv ====
// rebuilt two-channel spectrum stream
`timescale 1ns/1ps
`include "sep_config.svh"

module harmonic_synth (
    input  logic                 AD0_CLK,
    input  logic                 rst,
    input  logic                 start,
    input  sep_pkg::bin_t        fund_lo,
    input  sep_pkg::bin_t        fund_hi,
    input  sep_pkg::wave_flags_t tri_flags,
    input  logic                 out_ready,
    output logic                 out_valid,
    output logic                 out_last,
    output sep_pkg::bin_t        out_bin,
    output sep_pkg::amp_t        out_amp_lo,
    output sep_pkg::amp_t        out_amp_hi,
    output logic                 done
);
    import sep_pkg::*;

    localparam int   N    = `SEP_FRAME_LEN;
    localparam int   HALF = N / 2;
    localparam bin_t LAST = bin_t'(N - 1);

    // index i holds harmonic 2i+1
    localparam amp_t TRI_AMP [9] = '{
        `SEP_TRI_AMP_1,  `SEP_TRI_AMP_3,  `SEP_TRI_AMP_5,
        `SEP_TRI_AMP_7,  `SEP_TRI_AMP_9,  `SEP_TRI_AMP_11,
        `SEP_TRI_AMP_13, `SEP_TRI_AMP_15, `SEP_TRI_AMP_17
    };

    logic beat;

    // amplitude of bin b for one channel with fundamental f
    function automatic amp_t chan_amp(input bin_t b, input bin_t f, input logic is_tri);
        amp_t a;
        int   kf;
        a = '0;
        if (b != '0) begin
            if (is_tri) begin
                for (int i = 0; i < 9; i++) begin
                    kf = (2 * i + 1) * int'(f);
                    // positive bin and its mirror, only below nyquist
                    if (kf < HALF && (int'(b) == kf || int'(b) == N - kf)) begin
                        a = TRI_AMP[i];
                    end
                end
            end else if (b == f || int'(b) == N - int'(f)) begin
                a = amp_t'(`SEP_SIN_AMP);
            end
        end
        return a;
    endfunction

    assign beat     = out_valid && out_ready;
    assign out_last = out_valid && (out_bin == LAST);
    assign done     = beat && out_last; // frame fully drained

    // bin counter moves only on accepted beats
    always_ff @(posedge AD0_CLK) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_bin   <= '0;
        end else if (start) begin
            out_valid <= 1'b1;
            out_bin   <= '0;
        end else if (beat) begin
            if (out_bin == LAST) begin
                out_valid <= 1'b0;
                out_bin   <= '0;
            end else begin
                out_bin <= out_bin + 1'b1;
            end
        end
    end

    // data follows the counter, so it holds under back-pressure
    always_comb begin
        out_amp_lo = chan_amp(out_bin, fund_lo, tri_flags[0]);
        out_amp_hi = chan_amp(out_bin, fund_hi, tri_flags[1]);
    end

endmodule

// ==== hw/sep_ctrl.sv ====
// frame sequencing FSM
`timescale 1ns/1ps

module sep_ctrl (
    input  logic AD0_CLK,
    input  logic rst,
    input  logic in_valid,
    input  logic in_last,
    output logic in_ready,
    output logic buf_we,
    output logic load_active,
    output logic classify_start,
    input  logic classify_done,
    output logic synth_start,
    input  logic synth_done
);
    import sep_pkg::*;

    ctrl_state_t state;
    logic        in_beat;

    assign in_beat     = in_valid && in_ready;
    assign buf_we      = in_beat;             // every accepted bin goes to the buffer
    assign load_active = (state == ST_LOAD);

    always_ff @(posedge AD0_CLK) begin
        if (rst) begin
            state          <= ST_LOAD;
            in_ready       <= 1'b0;
            classify_start <= 1'b0;
            synth_start    <= 1'b0;
        end else begin
            classify_start <= 1'b0; // single-cycle pulses
            synth_start    <= 1'b0;
            case (state)
                ST_LOAD: begin
                    if (in_beat && in_last) begin
                        in_ready       <= 1'b0;
                        classify_start <= 1'b1;
                        state          <= ST_CLASSIFY;
                    end else begin
                        in_ready <= 1'b1; // also raises it right after reset
                    end
                end
                ST_CLASSIFY: begin
                    if (classify_done) begin
                        synth_start <= 1'b1;
                        state       <= ST_SYNTH;
                    end
                end
                ST_SYNTH: begin
                    // last output beat taken, next frame may load
                    if (synth_done) begin
                        in_ready <= 1'b1;
                        state    <= ST_LOAD;
                    end
                end
                default: begin
                    in_ready <= 1'b0;
                    state    <= ST_LOAD;
                end
            endcase
        end
    end

endmodule

// ==== hw/wave_separator.sv ====
// spectral wave separator top
`timescale 1ns/1ps

module wave_separator (
    input  logic                 AD0_CLK,
    input  logic                 rst,
    input  logic                 in_valid,
    input  sep_pkg::mag_t        in_mag,
    input  logic                 in_last,
    output logic                 in_ready,
    output logic                 out_valid,
    input  logic                 out_ready,
    output sep_pkg::bin_t        out_bin,
    output sep_pkg::amp_t        out_amp_lo,
    output sep_pkg::amp_t        out_amp_hi,
    output logic                 out_last,
    output sep_pkg::bin_t        fund_lo,
    output sep_pkg::bin_t        fund_hi,
    output sep_pkg::wave_flags_t tri_flags
);
    import sep_pkg::*;

    logic buf_we;
    logic load_active;
    logic classify_start, classify_done;
    logic synth_start, synth_done;
    bin_t wr_bin;
    bin_t rd_addr;
    mag_t rd_data;
    mag_t fund_lo_mag, fund_hi_mag;

    sep_ctrl u_ctrl (
        .AD0_CLK        (AD0_CLK),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_last        (in_last),
        .in_ready       (in_ready),
        .buf_we         (buf_we),
        .load_active    (load_active),
        .classify_start (classify_start),
        .classify_done  (classify_done),
        .synth_start    (synth_start),
        .synth_done     (synth_done)
    );

    spectrum_buffer u_buf (
        .AD0_CLK (AD0_CLK),
        .we      (buf_we),
        .waddr   (wr_bin),
        .wdata   (in_mag),
        .raddr   (rd_addr),
        .rdata   (rd_data)
    );

    peak_finder u_peak (
        .AD0_CLK     (AD0_CLK),
        .rst         (rst),
        .load_active (load_active),
        .beat        (buf_we),
        .mag         (in_mag),
        .wr_bin      (wr_bin),
        .fund_lo     (fund_lo),
        .fund_hi     (fund_hi),
        .fund_lo_mag (fund_lo_mag),
        .fund_hi_mag (fund_hi_mag)
    );

    wave_classifier u_class (
        .AD0_CLK     (AD0_CLK),
        .rst         (rst),
        .start       (classify_start),
        .fund_lo     (fund_lo),
        .fund_hi     (fund_hi),
        .fund_lo_mag (fund_lo_mag),
        .fund_hi_mag (fund_hi_mag),
        .raddr       (rd_addr),
        .rdata       (rd_data),
        .tri_flags   (tri_flags),
        .done        (classify_done)
    );

    harmonic_synth u_synth (
        .AD0_CLK    (AD0_CLK),
        .rst        (rst),
        .start      (synth_start),
        .fund_lo    (fund_lo),
        .fund_hi    (fund_hi),
        .tri_flags  (tri_flags),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_bin    (out_bin),
        .out_amp_lo (out_amp_lo),
        .out_amp_hi (out_amp_hi),
        .done       (synth_done)
    );

endmodule

// ==== sim/wave_separator_properties.sv ====
// wave separator stream properties
`timescale 1ns/1ps
`include "sep_config.svh"

module wave_separator_properties (
    input logic          AD0_CLK,
    input logic          rst,
    input logic          in_ready,
    input logic          out_valid,
    input logic          out_ready,
    input sep_pkg::bin_t out_bin,
    input sep_pkg::amp_t out_amp_lo,
    input sep_pkg::amp_t out_amp_hi,
    input logic          out_last
);
    import sep_pkg::*;

    localparam bin_t LAST = bin_t'(`SEP_FRAME_LEN - 1);

    int fail_count = 0; // failed assertions so far

    // a stalled beat keeps all its data
    hold_on_stall: assert property (@(posedge AD0_CLK) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_bin) && $stable(out_last)
                                       && $stable(out_amp_lo) && $stable(out_amp_hi)))
    else begin
        fail_count = fail_count + 1;
        $error("output beat changed while out_ready was low");
    end

    input_closed: assert property (@(posedge AD0_CLK) disable iff (rst)
        out_valid |-> !in_ready)
    else begin
        fail_count = fail_count + 1;
        $error("in_ready high while output stream active");
    end

    // bins step by one and the last flag closes the frame on the final bin
    last_on_final_bin: assert property (@(posedge AD0_CLK) disable iff (rst)
        (out_valid && out_ready) |=> (out_valid
            ? (!$past(out_last) && int'(out_bin) == int'($past(out_bin)) + 1)
            : ($past(out_last) && $past(out_bin) == LAST)))
    else begin
        fail_count = fail_count + 1;
        $error("out_last does not match final bin or bins out of order");
    end

endmodule

bind wave_separator wave_separator_properties u_props (
    .AD0_CLK    (AD0_CLK),
    .rst        (rst),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_bin    (out_bin),
    .out_amp_lo (out_amp_lo),
    .out_amp_hi (out_amp_hi),
    .out_last   (out_last)
);

// ==== sim/tb_wave_separator.sv ====
// wave separator testbench
`timescale 1ns/1ps
`include "sep_config.svh"

module tb_wave_separator;
    import sep_pkg::*;

    localparam int N           = `SEP_FRAME_LEN;
    localparam int HALF        = N / 2;
    localparam int NUM_ROWS    = 6;
    localparam int CYCLE_LIMIT = NUM_ROWS * (4 * N + 50);

    // one row per frame where kind 1 is triangle and 0 is sine
    int row_fa   [NUM_ROWS] = '{5, 9, 2, 12, 3, 31};
    int row_ka   [NUM_ROWS] = '{1, 0, 1, 0, 1, 0};
    int row_fb   [NUM_ROWS] = '{12, 4, 7, 28, 11, 1};
    int row_kb   [NUM_ROWS] = '{0, 1, 1, 0, 1, 1};
    int row_base [NUM_ROWS] = '{200000, 150000, 300000, 90000, 120000, 250000};

    logic        AD0_CLK;
    logic        rst;
    logic        in_valid;
    mag_t        in_mag;
    logic        in_last;
    logic        in_ready;
    logic        out_valid;
    logic        out_ready;
    bin_t        out_bin;
    amp_t        out_amp_lo;
    amp_t        out_amp_hi;
    logic        out_last;
    bin_t        fund_lo;
    bin_t        fund_hi;
    wave_flags_t tri_flags;

    int   seed       = 68080;
    int   cycles     = 0;
    int   checks     = 0;
    int   errors     = 0;
    int   row_errors = 0;
    mag_t spec [N];   // spectrum of the current row

    wave_separator u_dut (.*);

    initial begin
        AD0_CLK = 1'b0;
        forever #2 AD0_CLK = ~AD0_CLK;
    end

    always @(posedge AD0_CLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped: frames still unfinished after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input int exp_v, input int act_v);
        checks++;
        assert (exp_v == act_v) else begin
            $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
            errors++;
            row_errors++;
        end
    endtask

    function automatic int tri_amp(input int k);
        case (k)
            1:       return `SEP_TRI_AMP_1;
            3:       return `SEP_TRI_AMP_3;
            5:       return `SEP_TRI_AMP_5;
            7:       return `SEP_TRI_AMP_7;
            9:       return `SEP_TRI_AMP_9;
            11:      return `SEP_TRI_AMP_11;
            13:      return `SEP_TRI_AMP_13;
            15:      return `SEP_TRI_AMP_15;
            17:      return `SEP_TRI_AMP_17;
            default: return 0;
        endcase
    endfunction

    // expected rebuilt amplitude of bin b for a source at f
    function automatic int model_amp(input int b, input int f, input logic is_tri);
        int m;
        m = (b < HALF) ? b : N - b; // fold the mirror back
        if (b == 0 || m >= HALF) return 0;
        if (!is_tri) return (m == f) ? `SEP_SIN_AMP : 0;
        if (m % f == 0 && (m / f) % 2 == 1) return tri_amp(m / f);
        return 0;
    endfunction

    // 1/16 third harmonic rule on the built spectrum
    function automatic logic tri_expected(input int f);
        if (3 * f >= HALF) return 1'b0;
        return spec[3 * f] > (spec[f] >> `SEP_TRI_SHIFT);
    endfunction

    task automatic build_spectrum(input int r);
        for (int b = 0; b < N; b++) begin
            spec[b] = mag_t'($random(seed) & 15); // noise floor
        end
        for (int k = 1; k * row_fa[r] < HALF; k += 2) begin
            if (row_ka[r] == 1 || k == 1) spec[k * row_fa[r]] += row_base[r] / (k * k);
        end
        for (int k = 1; k * row_fb[r] < HALF; k += 2) begin
            if (row_kb[r] == 1 || k == 1) spec[k * row_fb[r]] += row_base[r] / (k * k);
        end
        for (int b = 1; b < HALF; b++) begin
            spec[N - b] = spec[b];
        end
    endtask

    // called on a falling edge and returns on the one after the in_last beat
    task automatic load_frame();
        int k;
        k = 0;
        while (k < N) begin
            in_valid = 1'b1;
            in_mag   = spec[k];
            in_last  = (k == N - 1);
            if (in_ready) k++; // beat goes on the next rising edge
            @(negedge AD0_CLK);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic drain_frame(input int fl, input int fh, input wave_flags_t fl_exp,
                               output int nbeat);
        int   exp_bin;
        logic frame_end;
        exp_bin   = 0;
        nbeat     = 0;
        frame_end = 1'b0;
        while (!frame_end) begin
            out_ready = ($random(seed) & 3) != 0;
            check_val("in_ready", 0, in_ready); // input blocked until out_last
            if (out_valid && out_ready) begin
                if (nbeat == 0) begin
                    check_val("fund_lo", fl, fund_lo);
                    check_val("fund_hi", fh, fund_hi);
                    check_val("tri_flags", fl_exp, tri_flags);
                end
                check_val("out_bin", exp_bin, out_bin);
                check_val("out_amp_lo", model_amp(out_bin, fl, fl_exp[0]), out_amp_lo);
                check_val("out_amp_hi", model_amp(out_bin, fh, fl_exp[1]), out_amp_hi);
                check_val("out_last", exp_bin == N - 1, out_last);
                frame_end = out_last || (exp_bin == N - 1);
                exp_bin++;
                nbeat++;
            end
            @(negedge AD0_CLK);
        end
        out_ready = 1'b0;
        check_val("beats per frame", N, nbeat);
    endtask

    initial begin
        int          fl;
        int          fh;
        int          nbeat;
        int          failed_rows;
        wave_flags_t fl_exp;
        failed_rows = 0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_mag    = '0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        repeat (3) @(negedge AD0_CLK);
        rst = 1'b0;
        check_val("in_ready", 0, in_ready);
        check_val("out_valid", 0, out_valid);
        @(negedge AD0_CLK);
        check_val("in_ready", 1, in_ready); // load opens one cycle after reset

        for (int r = 0; r < NUM_ROWS; r++) begin
            build_spectrum(r);
            fl = (row_fa[r] < row_fb[r]) ? row_fa[r] : row_fb[r];
            fh = (row_fa[r] < row_fb[r]) ? row_fb[r] : row_fa[r];
            fl_exp = {tri_expected(fh), tri_expected(fl)};
            load_frame();
            drain_frame(fl, fh, fl_exp, nbeat);
            $display("row %0d: fund %0d/%0d flags %b, %0d beats, %0d errors",
                     r, fl, fh, fl_exp, nbeat, row_errors);
            if (row_errors != 0) failed_rows++;
            row_errors = 0;
        end

        errors += u_dut.u_props.fail_count;
        $display("rows %0d, failing rows %0d, checks %0d, errors %0d, assertion failures %0d",
                 NUM_ROWS, failed_rows, checks, errors, u_dut.u_props.fail_count);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/sep_pkg.sv
hw/spectrum_buffer.sv
hw/peak_finder.sv
hw/wave_classifier.sv
hw/harmonic_synth.sv
hw/sep_ctrl.sv
hw/wave_separator.sv
sim/wave_separator_properties.sv
sim/tb_wave_separator.sv
